// ==== source/mmu_pkg.sv ====
// Sv39 address translation definitions
// Widths, vector types, PTE flag bit indices
// Privilege, access kind and page level codes
// Lookup, fill, CSR and flush structs
package mmu_pkg;

  // ==================================================
  // Widths and vector types
  // ==================================================
  localparam int PAGE_SHIFT = 12;  // 4 KiB base page
  localparam int VPN_W      = 27;  // VPN[2:0], 9 bits each
  localparam int PPN_W      = 44;
  localparam int PA_W       = 56;

  typedef logic [63:0]       vaddr_t;       // Bits 38:0 translated
  typedef logic [VPN_W-1:0]  vpn_t;         // vaddr[38:12]
  typedef logic [PPN_W-1:0]  ppn_t;
  typedef logic [PA_W-1:0]   paddr_t;
  typedef logic [7:0]        pte_flags_t;   // V R W X U G A D from bit 0
  typedef logic [1:0]        page_level_t;
  typedef logic [1:0]        priv_t;
  typedef logic [1:0]        access_t;

  // PTE flag positions
  localparam int PTE_V = 0;
  localparam int PTE_R = 1;
  localparam int PTE_W = 2;
  localparam int PTE_X = 3;
  localparam int PTE_U = 4;
  localparam int PTE_G = 5;  // Global
  localparam int PTE_A = 6;  // Accessed
  localparam int PTE_D = 7;  // Dirty

  // ==================================================
  // Codes
  // ==================================================
  localparam page_level_t LEVEL_4K = 2'd0;
  localparam page_level_t LEVEL_2M = 2'd1;
  localparam page_level_t LEVEL_1G = 2'd2;

  localparam priv_t PRIV_U = 2'd0;
  localparam priv_t PRIV_S = 2'd1;
  localparam priv_t PRIV_M = 2'd3;

  localparam access_t ACCESS_LOAD  = 2'd0;
  localparam access_t ACCESS_STORE = 2'd1;
  localparam access_t ACCESS_FETCH = 2'd2;

  // ==================================================
  // Structs
  // ==================================================
  typedef struct packed {
    logic    valid;
    vaddr_t  vaddr;
    access_t access;
  } tlb_req_t;

  typedef struct packed {
    logic   hit;
    logic   page_fault;
    paddr_t paddr;       // Only meaningful with hit
  } tlb_resp_t;

  typedef struct packed {
    logic        valid;
    vpn_t        vpn;
    ppn_t        ppn;
    pte_flags_t  flags;
    page_level_t level;
  } tlb_fill_t;

  typedef struct packed {
    logic  translation_on;  // satp.MODE != bare
    priv_t priv;
    logic  sum;
    logic  mxr;
  } tlb_csr_t;

  typedef struct packed {
    logic   all;
    logic   by_addr;
    vaddr_t addr;
  } tlb_flush_t;

endpackage

// ==== source/tlb_perm_check.sv ====
// PTE permission check for one access
// Leaf encoding, U bit against privilege and SUM,
// access kind against R, W, X and MXR
module tlb_perm_check (
  input  mmu_pkg::pte_flags_t flags,
  input  mmu_pkg::access_t    access,
  input  mmu_pkg::tlb_csr_t   csr,
  output logic                perm_ok
);

  logic flag_v, flag_r, flag_w, flag_x, flag_u;
  logic leaf_ok;  // Encoding and privilege pass
  logic kind_ok;  // Access kind allowed by flags

  assign flag_v = flags[mmu_pkg::PTE_V];
  assign flag_r = flags[mmu_pkg::PTE_R];
  assign flag_w = flags[mmu_pkg::PTE_W];
  assign flag_x = flags[mmu_pkg::PTE_X];
  assign flag_u = flags[mmu_pkg::PTE_U];

  // ==================================================
  // Encoding and privilege
  // ==================================================
  always_comb begin
    leaf_ok = 1'b1;
    if (!flag_v) begin
      leaf_ok = 1'b0;
    end else if (!flag_r && !flag_w && !flag_x) begin
      leaf_ok = 1'b0;                      // Pointer, not a leaf
    end else if (flag_w && !flag_r) begin
      leaf_ok = 1'b0;                      // Reserved combination
    end else if (csr.priv == mmu_pkg::PRIV_U) begin
      leaf_ok = flag_u;                    // User needs U page
    end else if (csr.priv == mmu_pkg::PRIV_S) begin
      leaf_ok = !(flag_u && !csr.sum);     // U page only with SUM
    end
    // M mode and code 2 skip the U checks
  end

  // Access kind
  always_comb begin
    case (access)
      mmu_pkg::ACCESS_FETCH: kind_ok = flag_x;
      mmu_pkg::ACCESS_STORE: kind_ok = flag_w;
      default:               kind_ok = flag_r || (flag_x && csr.mxr);  // Load
    endcase
  end

  assign perm_ok = leaf_ok && kind_ok;

endmodule

// ==== source/tlb.sv ====
// Fully associative Sv39 TLB
// Parallel VPN lookup, highest matching index wins
// Physical address from page level, permission check,
// flush all or by address, round-robin fill
module tlb #(
  parameter int TLB_ENTRIES = 8  // Power of two
) (
  input  logic                clk,
  input  logic                reset_n,
  input  mmu_pkg::tlb_req_t   req,
  input  mmu_pkg::tlb_fill_t  fill,
  input  mmu_pkg::tlb_csr_t   csr,
  input  mmu_pkg::tlb_flush_t flush,
  output mmu_pkg::tlb_resp_t  resp
);

  localparam int IDX_W  = $clog2(TLB_ENTRIES);
  localparam int PPN_W  = mmu_pkg::PPN_W;
  localparam int OFS_4K = mmu_pkg::PAGE_SHIFT;  // Offset bits per level
  localparam int OFS_2M = OFS_4K + 9;
  localparam int OFS_1G = OFS_4K + 18;

  // ==================================================
  // Entry storage
  // ==================================================
  logic [TLB_ENTRIES-1:0] entry_valid;
  mmu_pkg::vpn_t          entry_vpn   [TLB_ENTRIES];
  mmu_pkg::ppn_t          entry_ppn   [TLB_ENTRIES];
  mmu_pkg::pte_flags_t    entry_flags [TLB_ENTRIES];
  mmu_pkg::page_level_t   entry_level [TLB_ENTRIES];

  logic [IDX_W-1:0] replace_ptr;  // Next slot to fill

  // Lookup side
  mmu_pkg::vpn_t        req_vpn;
  mmu_pkg::vpn_t        flush_vpn;
  logic                 hit_found;
  logic [IDX_W-1:0]     hit_idx;
  logic                 hit;
  logic                 perm_ok;
  mmu_pkg::ppn_t        sel_ppn;
  mmu_pkg::pte_flags_t  sel_flags;
  mmu_pkg::page_level_t sel_level;
  mmu_pkg::paddr_t      paddr;

  assign req_vpn   = req.vaddr[OFS_4K +: mmu_pkg::VPN_W];    // vaddr[38:12]
  assign flush_vpn = flush.addr[OFS_4K +: mmu_pkg::VPN_W];

  // ==================================================
  // Parallel lookup
  // ==================================================
  always_comb begin
    hit_found = 1'b0;
    hit_idx   = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      // Full VPN compare, superpages too
      if (entry_valid[i] && (entry_vpn[i] == req_vpn)) begin
        hit_found = 1'b1;
        hit_idx   = IDX_W'(i);  // Later match overrides
      end
    end
  end

  assign hit = req.valid && csr.translation_on && hit_found;

  // Selected entry payload
  assign sel_ppn   = entry_ppn[hit_idx];
  assign sel_flags = entry_flags[hit_idx];
  assign sel_level = entry_level[hit_idx];

  // Physical address, offset width from level
  always_comb begin
    case (sel_level)
      mmu_pkg::LEVEL_2M: begin
        paddr = {sel_ppn[PPN_W-1:OFS_2M-OFS_4K], req.vaddr[OFS_2M-1:0]};
      end
      mmu_pkg::LEVEL_1G: begin
        paddr = {sel_ppn[PPN_W-1:OFS_1G-OFS_4K], req.vaddr[OFS_1G-1:0]};
      end
      default: begin
        paddr = {sel_ppn, req.vaddr[OFS_4K-1:0]};  // 4 KiB, level 3 too
      end
    endcase
  end

  tlb_perm_check perm_i (
    .flags   (sel_flags),
    .access  (req.access),
    .csr     (csr),
    .perm_ok (perm_ok)
  );

  assign resp = '{hit: hit, page_fault: hit && !perm_ok, paddr: paddr};

  // ==================================================
  // Flush and fill
  // ==================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      entry_valid <= '0;
      replace_ptr <= '0;
    end else begin
      if (flush.all) begin
        entry_valid <= '0;
      end else if (flush.by_addr) begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
          if (entry_vpn[i] == flush_vpn) begin
            entry_valid[i] <= 1'b0;
          end
        end
      end
      // Fill after flush, so the filled slot stays valid
      if (fill.valid) begin
        entry_valid[replace_ptr] <= 1'b1;
        replace_ptr              <= replace_ptr + 1'b1;  // Wraps at TLB_ENTRIES
      end
    end
  end

  // Payload write, guarded by entry_valid
  always_ff @(posedge clk) begin
    if (fill.valid) begin
      entry_vpn[replace_ptr]   <= fill.vpn;
      entry_ppn[replace_ptr]   <= fill.ppn;
      entry_flags[replace_ptr] <= fill.flags;
      entry_level[replace_ptr] <= fill.level;
    end
  end

endmodule

// ==== source/mmu_tlbs.sv ====
// Translation top level
// Instruction TLB and data TLB on shared CSR state and flushes
// Separate request, fill and response per TLB
module mmu_tlbs #(
  parameter int ITLB_ENTRIES = 4,
  parameter int DTLB_ENTRIES = 8
) (
  input  logic                clk,
  input  logic                reset_n,

  // Instruction side
  input  mmu_pkg::tlb_req_t   itlb_req,
  input  mmu_pkg::tlb_fill_t  itlb_fill,
  output mmu_pkg::tlb_resp_t  itlb_resp,

  // Data side
  input  mmu_pkg::tlb_req_t   dtlb_req,
  input  mmu_pkg::tlb_fill_t  dtlb_fill,
  output mmu_pkg::tlb_resp_t  dtlb_resp,

  // Shared by both TLBs
  input  mmu_pkg::tlb_csr_t   csr,
  input  mmu_pkg::tlb_flush_t flush
);

  // ==================================================
  // Instruction TLB
  // ==================================================
  tlb #(
    .TLB_ENTRIES (ITLB_ENTRIES)
  ) itlb_i (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (itlb_req),
    .fill    (itlb_fill),
    .csr     (csr),
    .flush   (flush),      // sfence hits both
    .resp    (itlb_resp)
  );

  // ==================================================
  // Data TLB
  // ==================================================
  tlb #(
    .TLB_ENTRIES (DTLB_ENTRIES)
  ) dtlb_i (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (dtlb_req),
    .fill    (dtlb_fill),
    .csr     (csr),
    .flush   (flush),
    .resp    (dtlb_resp)
  );

endmodule

// ==== dv/tlb_sva.sv ====
// Concurrent checks on one TLB response
// Fault implies hit, hit implies a translated request,
// quiet response while in reset
module tlb_sva (
  input logic                clk,
  input logic                reset_n,
  input mmu_pkg::tlb_req_t   req,
  input mmu_pkg::tlb_csr_t   csr,
  input mmu_pkg::tlb_resp_t  resp
);
  timeunit 1ns;
  timeprecision 100ps;

  fault_needs_hit: assert property (@(posedge clk) disable iff (!reset_n)
    resp.page_fault |-> resp.hit)
    else $error("page_fault raised without hit");

  hit_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
    resp.hit |-> (req.valid && csr.translation_on))  // No hit in bare mode
    else $error("hit without a valid request in translated mode");

  quiet_in_reset: assert property (@(posedge clk)
    !reset_n |-> (!resp.hit && !resp.page_fault))
    else $error("hit or page_fault high during reset");

endmodule

bind tlb tlb_sva sva_i (.clk(clk), .reset_n(reset_n), .req(req), .csr(csr), .resp(resp));

// ==== dv/tlb_tb.sv ====
// Testbench for the Sv39 instruction and data TLBs
// Random fills, lookups and flushes against a reference model
// Compare tasks, watchdog, per-test lines and closing counts
module tlb_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ITLB_N      = 4;
  localparam int DTLB_N      = 8;
  localparam int PERM_ITERS  = 200;
  // One cycle per fill, flush and lookup, reset included
  localparam int PLANNED_OPS = 11 * (ITLB_N + DTLB_N) + PERM_ITERS + 42;
  localparam mmu_pkg::pte_flags_t FLAGS_ALL = 8'hCF;  // V R W X A D
  localparam mmu_pkg::paddr_t     PA_ONES   = '1;

  logic                clk;
  logic                reset_n;
  mmu_pkg::tlb_req_t   req  [2];  // Index 0 itlb, 1 dtlb
  mmu_pkg::tlb_fill_t  fill [2];
  mmu_pkg::tlb_resp_t  resp [2];
  mmu_pkg::tlb_csr_t   csr, csr_m, csr_off;
  mmu_pkg::tlb_flush_t flush;

  // Reference model, valid bit kept in the fill struct
  mmu_pkg::tlb_fill_t m_ent [2][DTLB_N];
  int    m_ptr [2];
  int    n_entries [2] = '{ITLB_N, DTLB_N};
  string tname [2] = '{"itlb_resp", "dtlb_resp"};
  int    vpn_seq, tests, checks, errors;

  mmu_tlbs #(.ITLB_ENTRIES(ITLB_N), .DTLB_ENTRIES(DTLB_N)) dut_i (
    .clk(clk), .reset_n(reset_n),
    .itlb_req(req[0]), .itlb_fill(fill[0]), .itlb_resp(resp[0]),
    .dtlb_req(req[1]), .dtlb_fill(fill[1]), .dtlb_resp(resp[1]),
    .csr(csr), .flush(flush)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(PLANNED_OPS * 10 * 4);  // Four times the planned run length
    $display("Watchdog expired after %0d ns, run did not complete", PLANNED_OPS * 40);
    $display("Result: FAILED");
    $finish;
  end

  // ==================================================
  // Compare tasks
  // ==================================================
  task automatic check_hit(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s.hit: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_fault(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s.page_fault: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_paddr(string name, mmu_pkg::paddr_t exp, mmu_pkg::paddr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s.paddr: expected %h, actual %h", name, exp, act);
    end
  endtask

  // ==================================================
  // Model rules and stimulus
  // ==================================================
  function automatic logic allows(mmu_pkg::pte_flags_t f, mmu_pkg::access_t acc,
                                  mmu_pkg::tlb_csr_t c);
    logic r, w, x, u;
    r = f[mmu_pkg::PTE_R];
    w = f[mmu_pkg::PTE_W];
    x = f[mmu_pkg::PTE_X];
    u = f[mmu_pkg::PTE_U];
    if (!f[mmu_pkg::PTE_V] || !(r || w || x) || (w && !r)) return 1'b0;  // Not a usable leaf
    if (c.priv == mmu_pkg::PRIV_U && !u) return 1'b0;
    if (c.priv == mmu_pkg::PRIV_S && u && !c.sum) return 1'b0;
    if (acc == mmu_pkg::ACCESS_FETCH) return x;
    if (acc == mmu_pkg::ACCESS_STORE) return w;
    return r || (x && c.mxr);  // Load, MXR lets X pages read
  endfunction

  function automatic mmu_pkg::vpn_t fresh_vpn();
    vpn_seq++;
    return {19'($urandom), 8'(vpn_seq)};  // Low byte unique per call
  endfunction

  task automatic idle();
    req   = '{'0, '0};
    fill  = '{'0, '0};
    flush = '0;
  endtask

  task automatic fill_entry(int sel, mmu_pkg::vpn_t vpn, mmu_pkg::pte_flags_t flags);
    mmu_pkg::tlb_fill_t f;
    @(negedge clk);
    idle();
    f = '{valid: 1'b1, vpn: vpn, ppn: {12'($urandom), 32'($urandom)}, flags: flags,
          level: mmu_pkg::page_level_t'($urandom_range(2, 0))};
    fill[sel] = f;
    m_ent[sel][m_ptr[sel]] = f;  // Visible from the next cycle
    m_ptr[sel] = (m_ptr[sel] + 1) % n_entries[sel];
  endtask

  task automatic flush_cmd(logic all, logic by_addr, mmu_pkg::vpn_t vpn);
    @(negedge clk);
    idle();
    flush = '{all: all, by_addr: by_addr, addr: {25'($urandom), vpn, 12'($urandom)}};
    for (int s = 0; s < 2; s++) begin  // Shared by both TLBs
      for (int i = 0; i < n_entries[s]; i++) begin
        if (all || (by_addr && m_ent[s][i].vpn == vpn)) m_ent[s][i].valid = 1'b0;
      end
    end
  endtask

  task automatic lookup(int sel, mmu_pkg::vpn_t vpn, mmu_pkg::access_t acc,
                        mmu_pkg::tlb_csr_t c);
    mmu_pkg::vaddr_t va;
    mmu_pkg::paddr_t mask;
    int   idx;
    logic exp_hit;
    @(negedge clk);
    idle();
    va = {25'($urandom), vpn, 12'($urandom)};  // Upper bits ignored by Sv39
    req[sel] = '{valid: 1'b1, vaddr: va, access: acc};
    csr = c;
    idx = -1;
    for (int i = 0; i < n_entries[sel]; i++) begin
      if (m_ent[sel][i].valid && m_ent[sel][i].vpn == vpn) idx = i;  // Highest index wins
    end
    exp_hit = (idx >= 0) && c.translation_on;
    #2;  // Combinational response settled
    check_hit(tname[sel], exp_hit, resp[sel].hit);
    check_fault(tname[sel], exp_hit ? !allows(m_ent[sel][idx].flags, acc, c) : 1'b0,
                resp[sel].page_fault);
    if (exp_hit) begin
      mask = ~(PA_ONES << (12 + 9 * int'(m_ent[sel][idx].level)));  // Offset bits
      check_paddr(tname[sel], ({m_ent[sel][idx].ppn, 12'h000} & ~mask) |
                  (mmu_pkg::paddr_t'(va) & mask), resp[sel].paddr);
    end
  endtask

  // Every model slot, then one VPN never filled
  task automatic sweep(int sel, mmu_pkg::tlb_csr_t c);
    for (int i = 0; i < n_entries[sel]; i++) lookup(sel, m_ent[sel][i].vpn, 2'd0, c);
    lookup(sel, fresh_vpn(), mmu_pkg::ACCESS_LOAD, c);
  endtask

  task automatic end_test(string name, int errs_before);
    tests++;
    $display("Test %0d %s: %0d errors, %0d checks so far", tests, name,
             errors - errs_before, checks);
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    int e0, sel, slot;
    mmu_pkg::vpn_t     v;
    mmu_pkg::tlb_csr_t c;
    void'($urandom(86269));
    csr_m   = '{translation_on: 1'b1, priv: mmu_pkg::PRIV_M, sum: 1'b0, mxr: 1'b0};
    csr_off = '{translation_on: 1'b0, priv: mmu_pkg::PRIV_M, sum: 1'b0, mxr: 1'b0};
    idle();
    req[0].valid = 1'b1;  // Lookups in reset must still miss
    req[1].valid = 1'b1;
    csr     = csr_m;
    reset_n = 1'b0;
    foreach (m_ent[s, i]) m_ent[s][i] = '0;
    m_ptr = '{0, 0};
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    e0 = errors;  // Fills at random levels
    for (int s = 0; s < 2; s++) begin
      for (int k = 0; k < n_entries[s]; k++) fill_entry(s, fresh_vpn(), FLAGS_ALL);
      sweep(s, csr_m);
    end
    end_test("fill_lookup", e0);

    e0 = errors;
    repeat (10) lookup(int'($urandom_range(1, 0)), fresh_vpn(), 2'd0, csr_m);
    sweep(0, csr_off);  // Bare mode never hits
    sweep(1, csr_off);
    end_test("miss", e0);

    e0 = errors;
    for (int s = 0; s < 2; s++) begin
      for (int k = 0; k < n_entries[s]; k++) fill_entry(s, fresh_vpn(), 8'($urandom));
    end
    repeat (PERM_ITERS) begin
      sel  = int'($urandom_range(1, 0));
      slot = int'($urandom_range(n_entries[sel] - 1, 0));
      c    = '{translation_on: 1'b1, priv: 2'($urandom), sum: 1'($urandom), mxr: 1'($urandom)};
      lookup(sel, m_ent[sel][slot].vpn, mmu_pkg::access_t'($urandom_range(2, 0)), c);
    end
    end_test("permissions", e0);

    e0 = errors;
    for (int s = 0; s < 2; s++) begin
      for (int k = 0; k < n_entries[s]; k++) fill_entry(s, fresh_vpn(), FLAGS_ALL);
    end
    flush_cmd(1'b0, 1'b1, m_ent[1][2].vpn);
    flush_cmd(1'b0, 1'b1, m_ent[0][1].vpn);
    sweep(0, csr_m);
    sweep(1, csr_m);
    flush_cmd(1'b1, 1'b0, '0);
    sweep(0, csr_m);
    sweep(1, csr_m);
    end_test("flush", e0);

    e0 = errors;  // One fill more than the TLB holds
    for (int s = 0; s < 2; s++) begin
      v = fresh_vpn();
      fill_entry(s, v, FLAGS_ALL);
      repeat (n_entries[s]) fill_entry(s, fresh_vpn(), FLAGS_ALL);
      lookup(s, v, mmu_pkg::ACCESS_LOAD, csr_m);  // Oldest entry replaced
      sweep(s, csr_m);
    end
    end_test("round_robin", e0);

    e0 = errors;
    for (int s = 0; s < 2; s++) begin
      fill_entry(s, fresh_vpn(), FLAGS_ALL);
      v = fresh_vpn();
      fill_entry(s, v, FLAGS_ALL);
      flush_cmd(1'b0, 1'b1, v);  // VPN only held by TLB s
      sweep(1 - s, csr_m);
      sweep(s, csr_m);
    end
    end_test("isolation", e0);

    @(negedge clk);
    idle();
    $display("Done: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
source/mmu_pkg.sv
source/tlb_perm_check.sv
source/tlb.sv
source/mmu_tlbs.sv
dv/tlb_sva.sv
dv/tlb_tb.sv

// ==== Makefile ====
# Verilator build and run of the TLB testbench

VERILATOR ?= verilator
TOP       ?= tlb_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || (echo "Pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
